//--- fpuPkg.sv
// #########################################################################
// FP16 only: 1 sign, 5 exponent and 10 fraction bits, truncating rounding.
// Condition code bit positions are fixed here for the whole design.
// #########################################################################

package fpuPkg;

  // #########################################################################
  // Format
  // #########################################################################

  localparam int BIT_WIDTH = 16;
  localparam int EXP_WIDTH = 5;
  localparam int SIG_WIDTH = 10;
  localparam int EXP_BIAS = 15;
  localparam int EXP_MAX_FINITE = 30;

  // Signed working width for exponent math, wide enough for 2*30 - 15 + 1
  localparam int EXP_CALC_WIDTH = EXP_WIDTH + 2;

  // Leading-zero count over the 11-bit significand
  localparam int LZC_WIDTH = $clog2(SIG_WIDTH + 1);

  // Shift amount taken from the low bits of operand 2
  localparam int SHAMT_WIDTH = 4;

  // Quiet NaN returned for any infinity or NaN input
  localparam logic [BIT_WIDTH-1:0] CANON_NAN = 16'h7E00;

  // #########################################################################
  // Condition code bit indices
  // #########################################################################

  localparam int CC_Z = 3;
  localparam int CC_C = 2;
  localparam int CC_N = 1;
  localparam int CC_V = 0;

  // DIV is decoded but not implemented
  typedef enum logic [2:0] {
    FPU_ADD = 3'd0,
    FPU_SUB = 3'd1,
    FPU_MUL = 3'd2,
    FPU_DIV = 3'd3,
    FPU_SHL = 3'd4,
    FPU_SHR = 3'd5
  } fpuOp_t;

endpackage : fpuPkg

//--- fpuUnpack.sv
// #########################################################################
// Subnormals are flushed here: a zero exponent always yields a zero sig.
// Exponent all ones on either side raises anySpecial for the result stage.
// #########################################################################

module fpuUnpack (
  input  logic [fpuPkg::BIT_WIDTH-1:0] fpuIn1,
  input  logic [fpuPkg::BIT_WIDTH-1:0] fpuIn2,
  output logic                         sign1,
  output logic                         sign2,
  output logic [fpuPkg::EXP_WIDTH-1:0] exp1,
  output logic [fpuPkg::EXP_WIDTH-1:0] exp2,
  output logic [fpuPkg::SIG_WIDTH:0]   sig1,
  output logic [fpuPkg::SIG_WIDTH:0]   sig2,
  output logic                         isZero1,
  output logic                         isZero2,
  output logic                         anySpecial
);

  logic [fpuPkg::SIG_WIDTH-1:0] frac1;
  logic [fpuPkg::SIG_WIDTH-1:0] frac2;
  logic                         isSpecial1;
  logic                         isSpecial2;

  // Field split
  assign sign1 = fpuIn1[fpuPkg::BIT_WIDTH-1];
  assign sign2 = fpuIn2[fpuPkg::BIT_WIDTH-1];
  assign exp1  = fpuIn1[fpuPkg::BIT_WIDTH-2 -: fpuPkg::EXP_WIDTH];
  assign exp2  = fpuIn2[fpuPkg::BIT_WIDTH-2 -: fpuPkg::EXP_WIDTH];
  assign frac1 = fpuIn1[fpuPkg::SIG_WIDTH-1:0];
  assign frac2 = fpuIn2[fpuPkg::SIG_WIDTH-1:0];

  // Zero exponent covers true zero and subnormals alike
  assign isZero1 = (exp1 == '0);
  assign isZero2 = (exp2 == '0);

  // Hidden bit, or nothing at all when flushed
  assign sig1 = isZero1 ? '0 : {1'b1, frac1};
  assign sig2 = isZero2 ? '0 : {1'b1, frac2};

  // Infinity and NaN are not told apart
  assign isSpecial1 = (exp1 == '1);
  assign isSpecial2 = (exp2 == '1);
  assign anySpecial = isSpecial1 | isSpecial2;

endmodule : fpuUnpack

//--- fpuAddSub.sv
// #########################################################################
// No guard bits: the aligned operand is truncated, so results round to zero.
// Special inputs pass through as garbage and are replaced by the result stage.
// #########################################################################

module fpuAddSub (
  input  fpuPkg::fpuOp_t               op,
  input  logic                         sign1,
  input  logic                         sign2,
  input  logic [fpuPkg::EXP_WIDTH-1:0] exp1,
  input  logic [fpuPkg::EXP_WIDTH-1:0] exp2,
  input  logic [fpuPkg::SIG_WIDTH:0]   sig1,
  input  logic [fpuPkg::SIG_WIDTH:0]   sig2,
  input  logic                         isZero1,
  input  logic                         isZero2,
  output logic [fpuPkg::BIT_WIDTH-1:0] addSubOut,
  output logic                         addSubCarry
);

  logic                                     sub;
  logic                                     effSign2;
  logic                                     swap;
  logic                                     bigSign;
  logic [fpuPkg::EXP_WIDTH-1:0]             bigExp;
  logic [fpuPkg::EXP_WIDTH-1:0]             smallExp;
  logic [fpuPkg::EXP_WIDTH-1:0]             expDiff;
  logic [fpuPkg::SIG_WIDTH:0]               bigSig;
  logic [fpuPkg::SIG_WIDTH:0]               smallSig;
  logic [fpuPkg::SIG_WIDTH:0]               alignedSig;
  logic [fpuPkg::SIG_WIDTH+1:0]             magSum;
  logic [fpuPkg::LZC_WIDTH-1:0]             lz;
  logic [fpuPkg::SIG_WIDTH:0]               normSig;
  logic signed [fpuPkg::EXP_CALC_WIDTH-1:0] normExp;

  // SUB is ADD with the second sign flipped
  assign sub      = (op == fpuPkg::FPU_SUB);
  assign effSign2 = sign2 ^ sub;

  // #########################################################################
  // Order by magnitude and align
  // #########################################################################

  assign swap     = {exp2, sig2} > {exp1, sig1};
  assign bigSign  = swap ? effSign2 : sign1;
  assign bigExp   = swap ? exp2 : exp1;
  assign smallExp = swap ? exp1 : exp2;
  assign bigSig   = swap ? sig2 : sig1;
  assign smallSig = swap ? sig1 : sig2;

  assign expDiff    = bigExp - smallExp;
  assign alignedSig = smallSig >> expDiff;

  // Never negative since the larger magnitude comes first
  assign magSum = (sign1 == effSign2) ? {1'b0, bigSig} + {1'b0, alignedSig}
                                      : {1'b0, bigSig} - {1'b0, alignedSig};

  // #########################################################################
  // Normalize
  // #########################################################################

  always_comb begin
    lz = '0;
    // Highest set bit wins, as the loop runs upward
    for (int i = 0; i <= fpuPkg::SIG_WIDTH; i++) begin
      if (magSum[i]) begin
        lz = fpuPkg::LZC_WIDTH'(fpuPkg::SIG_WIDTH - i);
      end
    end

    if (magSum[fpuPkg::SIG_WIDTH+1]) begin
      // Carry out, one right shift
      normSig = magSum[fpuPkg::SIG_WIDTH+1:1];
      normExp = fpuPkg::EXP_CALC_WIDTH'(bigExp) + fpuPkg::EXP_CALC_WIDTH'(1);
    end else begin
      normSig = magSum[fpuPkg::SIG_WIDTH:0] << lz;
      normExp = fpuPkg::EXP_CALC_WIDTH'(bigExp) - fpuPkg::EXP_CALC_WIDTH'(lz);
    end
  end

  // #########################################################################
  // Pack
  // #########################################################################

  always_comb begin
    addSubCarry = 1'b0;
    if (isZero1 && isZero2) begin
      // Only -0 + -0 stays negative
      addSubOut = {sign1 & effSign2, {(fpuPkg::BIT_WIDTH-1){1'b0}}};
    end else if (isZero2) begin
      addSubOut = {sign1, exp1, sig1[fpuPkg::SIG_WIDTH-1:0]};
    end else if (isZero1) begin
      addSubOut = {effSign2, exp2, sig2[fpuPkg::SIG_WIDTH-1:0]};
    end else if (magSum == '0) begin
      // Exact cancellation
      addSubOut = '0;
    end else if (normExp < 1) begin
      addSubOut = {bigSign, {(fpuPkg::BIT_WIDTH-1){1'b0}}};
    end else if (normExp > fpuPkg::EXP_MAX_FINITE) begin
      addSubCarry = magSum[fpuPkg::SIG_WIDTH+1];
      addSubOut   = {bigSign, {fpuPkg::EXP_WIDTH{1'b1}}, {fpuPkg::SIG_WIDTH{1'b0}}};
    end else begin
      addSubCarry = magSum[fpuPkg::SIG_WIDTH+1];
      addSubOut   = {bigSign, normExp[fpuPkg::EXP_WIDTH-1:0],
                     normSig[fpuPkg::SIG_WIDTH-1:0]};
    end
  end

endmodule : fpuAddSub

//--- fpuMul.sv
// #########################################################################
// Product is truncated after at most one normalizing shift.
// Underflow flushes to signed zero, overflow saturates to signed infinity.
// #########################################################################

module fpuMul (
  input  logic                         sign1,
  input  logic                         sign2,
  input  logic [fpuPkg::EXP_WIDTH-1:0] exp1,
  input  logic [fpuPkg::EXP_WIDTH-1:0] exp2,
  input  logic [fpuPkg::SIG_WIDTH:0]   sig1,
  input  logic [fpuPkg::SIG_WIDTH:0]   sig2,
  input  logic                         isZero1,
  input  logic                         isZero2,
  output logic [fpuPkg::BIT_WIDTH-1:0] mulOut
);

  logic                                     resSign;
  logic [2*fpuPkg::SIG_WIDTH+1:0]           product;
  logic                                     prodHi;
  logic [fpuPkg::SIG_WIDTH-1:0]             fracOut;
  logic signed [fpuPkg::EXP_CALC_WIDTH-1:0] expOut;

  assign resSign = sign1 ^ sign2;

  // Both inputs carry the hidden bit, so the product lies in [1, 4)
  assign product = sig1 * sig2;
  assign prodHi  = product[2*fpuPkg::SIG_WIDTH+1];

  // Drop the leading one and keep the next 10 bits
  assign fracOut = prodHi ? product[2*fpuPkg::SIG_WIDTH -: fpuPkg::SIG_WIDTH]
                          : product[2*fpuPkg::SIG_WIDTH-1 -: fpuPkg::SIG_WIDTH];

  // Biased sum, rebiased, plus one when the product reached 2
  assign expOut = fpuPkg::EXP_CALC_WIDTH'(exp1)
                + fpuPkg::EXP_CALC_WIDTH'(exp2)
                + fpuPkg::EXP_CALC_WIDTH'(prodHi)
                - fpuPkg::EXP_CALC_WIDTH'(fpuPkg::EXP_BIAS);

  always_comb begin
    if (isZero1 || isZero2) begin
      mulOut = {resSign, {(fpuPkg::BIT_WIDTH-1){1'b0}}};
    end else if (expOut < 1) begin
      // Would be subnormal or smaller
      mulOut = {resSign, {(fpuPkg::BIT_WIDTH-1){1'b0}}};
    end else if (expOut > fpuPkg::EXP_MAX_FINITE) begin
      mulOut = {resSign, {fpuPkg::EXP_WIDTH{1'b1}}, {fpuPkg::SIG_WIDTH{1'b0}}};
    end else begin
      mulOut = {resSign, expOut[fpuPkg::EXP_WIDTH-1:0], fracOut};
    end
  end

endmodule : fpuMul

//--- fpuResult.sv
// #########################################################################
// The only registered stage. Outputs hold while resultValid is low.
// #########################################################################

module fpuResult (
  input  logic                         clk,
  input  logic                         rstN,
  input  logic                         opValid,
  input  fpuPkg::fpuOp_t               op,
  input  logic [fpuPkg::BIT_WIDTH-1:0] fpuIn1,
  input  logic [fpuPkg::BIT_WIDTH-1:0] fpuIn2,
  input  logic [fpuPkg::BIT_WIDTH-1:0] addSubOut,
  input  logic [fpuPkg::BIT_WIDTH-1:0] mulOut,
  input  logic                         addSubCarry,
  input  logic                         anySpecial,
  output logic [fpuPkg::BIT_WIDTH-1:0] fpuOut,
  output logic [3:0]                   condCodes,
  output logic                         resultValid
);

  logic [fpuPkg::SHAMT_WIDTH-1:0] shamt;
  logic [fpuPkg::BIT_WIDTH:0]     shlWide;
  logic [fpuPkg::BIT_WIDTH:0]     shrWide;
  logic [fpuPkg::BIT_WIDTH-1:0]   resNext;
  logic                           carryNext;
  logic                           isArith;
  logic [3:0]                     ccNext;

  // Extra bit on each side catches the last bit shifted out
  assign shamt   = fpuIn2[fpuPkg::SHAMT_WIDTH-1:0];
  assign shlWide = {1'b0, fpuIn1} << shamt;
  assign shrWide = {fpuIn1, 1'b0} >> shamt;

  always_comb begin
    resNext   = '0;
    carryNext = 1'b0;
    isArith   = 1'b0;
    case (op)
      fpuPkg::FPU_ADD, fpuPkg::FPU_SUB: begin
        isArith   = 1'b1;
        resNext   = anySpecial ? fpuPkg::CANON_NAN : addSubOut;
        carryNext = addSubCarry & ~anySpecial;
      end
      fpuPkg::FPU_MUL: begin
        isArith = 1'b1;
        resNext = anySpecial ? fpuPkg::CANON_NAN : mulOut;
      end
      fpuPkg::FPU_SHL: begin
        resNext   = shlWide[fpuPkg::BIT_WIDTH-1:0];
        carryNext = shlWide[fpuPkg::BIT_WIDTH];
      end
      fpuPkg::FPU_SHR: begin
        resNext   = shrWide[fpuPkg::BIT_WIDTH:1];
        carryNext = shrWide[0];
      end
      default: begin
        // DIV and unused codes return zero
        resNext = '0;
      end
    endcase
  end

  // #########################################################################
  // Condition codes
  // #########################################################################

  always_comb begin
    ccNext = '0;
    if (op != fpuPkg::FPU_DIV) begin
      ccNext[fpuPkg::CC_Z] = (resNext[fpuPkg::BIT_WIDTH-2:0] == '0);
      ccNext[fpuPkg::CC_C] = carryNext;
      ccNext[fpuPkg::CC_N] = isArith & resNext[fpuPkg::BIT_WIDTH-1];
      // All-ones exponent means infinity or the canonical NaN
      ccNext[fpuPkg::CC_V] = isArith
                           & (resNext[fpuPkg::BIT_WIDTH-2 -: fpuPkg::EXP_WIDTH] == '1);
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      resultValid <= 1'b0;
      fpuOut      <= '0;
      condCodes   <= '0;
    end else begin
      resultValid <= opValid;
      if (opValid) begin
        fpuOut    <= resNext;
        condCodes <= ccNext;
      end
    end
  end

endmodule : fpuResult

//--- fpu.sv
// #########################################################################
// One-cycle latency, a new op every cycle, no back-pressure on resultValid.
// #########################################################################

module fpu (
  input  logic                         clk,
  input  logic                         rstN,
  input  logic                         opValid,
  input  fpuPkg::fpuOp_t               op,
  input  logic [fpuPkg::BIT_WIDTH-1:0] fpuIn1,
  input  logic [fpuPkg::BIT_WIDTH-1:0] fpuIn2,
  output logic [fpuPkg::BIT_WIDTH-1:0] fpuOut,
  output logic [3:0]                   condCodes,
  output logic                         resultValid
);

  logic                         sign1;
  logic                         sign2;
  logic [fpuPkg::EXP_WIDTH-1:0] exp1;
  logic [fpuPkg::EXP_WIDTH-1:0] exp2;
  logic [fpuPkg::SIG_WIDTH:0]   sig1;
  logic [fpuPkg::SIG_WIDTH:0]   sig2;
  logic                         isZero1;
  logic                         isZero2;
  logic                         anySpecial;
  logic [fpuPkg::BIT_WIDTH-1:0] addSubOut;
  logic                         addSubCarry;
  logic [fpuPkg::BIT_WIDTH-1:0] mulOut;

  fpuUnpack unpack (
    .fpuIn1(fpuIn1), .fpuIn2(fpuIn2),
    .sign1(sign1), .sign2(sign2), .exp1(exp1), .exp2(exp2),
    .sig1(sig1), .sig2(sig2), .isZero1(isZero1), .isZero2(isZero2),
    .anySpecial(anySpecial)
  );

  fpuAddSub addSub (
    .op(op), .sign1(sign1), .sign2(sign2), .exp1(exp1), .exp2(exp2),
    .sig1(sig1), .sig2(sig2), .isZero1(isZero1), .isZero2(isZero2),
    .addSubOut(addSubOut), .addSubCarry(addSubCarry)
  );

  fpuMul mul (
    .sign1(sign1), .sign2(sign2), .exp1(exp1), .exp2(exp2),
    .sig1(sig1), .sig2(sig2), .isZero1(isZero1), .isZero2(isZero2),
    .mulOut(mulOut)
  );

  fpuResult result (
    .clk(clk), .rstN(rstN), .opValid(opValid), .op(op),
    .fpuIn1(fpuIn1), .fpuIn2(fpuIn2), .addSubOut(addSubOut), .mulOut(mulOut),
    .addSubCarry(addSubCarry), .anySpecial(anySpecial),
    .fpuOut(fpuOut), .condCodes(condCodes), .resultValid(resultValid)
  );

endmodule : fpu

//--- fpuTb.sv
// #########################################################################
// Random FP16 ops from a seeded LFSR, checked against a bit-exact model.
// Outputs are sampled on the falling edge, one cycle after each strobe.
// #########################################################################

module fpuTb;

  localparam int DRAIN_LIMIT = 8;
  localparam int RANDOM_OPS = 400;

  logic                         clk;
  logic                         rstN;
  logic                         opValid;
  fpuPkg::fpuOp_t               op;
  logic [fpuPkg::BIT_WIDTH-1:0] fpuIn1;
  logic [fpuPkg::BIT_WIDTH-1:0] fpuIn2;
  logic [fpuPkg::BIT_WIDTH-1:0] fpuOut;
  logic [3:0]                   condCodes;
  logic                         resultValid;

  logic [15:0]    lfsrState;
  int             cycle;
  int             checks;
  int             valueErrors;
  int             protoErrors;
  logic [15:0]    expWord[$];
  logic [3:0]     expCond[$];
  fpuPkg::fpuOp_t expOp[$];
  string          expName[$];
  int             expCycle[$];
  fpuPkg::fpuOp_t sampledOps[$];

  fpu DUT (
    .clk(clk), .rstN(rstN), .opValid(opValid), .op(op),
    .fpuIn1(fpuIn1), .fpuIn2(fpuIn2),
    .fpuOut(fpuOut), .condCodes(condCodes), .resultValid(resultValid)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (rstN && opValid) begin
      sampledOps.push_back(op);
    end
  end

  // #########################################################################
  // Random numbers
  // #########################################################################

  function automatic logic [15:0] lfsrNext(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [15:0] randBits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsrState = lfsrNext(lfsrState);
      v = {v[14:0], lfsrState[0]};
    end
    return v;
  endfunction

  // Mix of zero/subnormal, special and normal exponents
  function automatic logic [15:0] randOperand();
    logic [2:0] kind;
    logic [4:0] e;
    logic       s;
    logic [9:0] f;
    kind = randBits(3);
    s = randBits(1);
    f = randBits(10);
    e = randBits(5);
    if (kind == 0) e = 5'd0;
    else if (kind == 1) e = 5'h1F;
    else if (e == 5'd0) e = 5'd1;
    else if (e == 5'h1F) e = 5'd30;
    return {s, e, f};
  endfunction

  // #########################################################################
  // Reference model
  // #########################################################################

  task automatic modelOp(input fpuPkg::fpuOp_t o, input logic [15:0] a,
                         input logic [15:0] b, output logic [15:0] res,
                         output logic [3:0] cc);
    int   ea;
    int   eb;
    int   ma;
    int   mb;
    int   eBig;
    int   mBig;
    int   mSmall;
    int   mag;
    int   expR;
    int   sh;
    logic sa;
    logic sb;
    logic sBig;
    logic carry;
    logic arith;
    logic special;
    sa = a[15];
    sb = b[15];
    ea = a[14:10];
    eb = b[14:10];
    ma = (ea == 0) ? 0 : 1024 + a[9:0];
    mb = (eb == 0) ? 0 : 1024 + b[9:0];
    special = (ea == 31) || (eb == 31);
    carry = 1'b0;
    arith = 1'b0;
    res = '0;
    sh = b[3:0];
    case (o)
      fpuPkg::FPU_ADD, fpuPkg::FPU_SUB: begin
        arith = 1'b1;
        if (o == fpuPkg::FPU_SUB) sb = ~sb;
        if (special) res = fpuPkg::CANON_NAN;
        else if (ea == 0 && eb == 0) res = {sa & sb, 15'd0};
        else if (eb == 0) res = a;
        else if (ea == 0) res = {sb, b[14:0]};
        else begin
          if (eb * 2048 + mb > ea * 2048 + ma) begin
            sBig = sb;
            eBig = eb;
            mBig = mb;
            mSmall = ma >> (eb - ea);
          end else begin
            sBig = sa;
            eBig = ea;
            mBig = ma;
            mSmall = mb >> (ea - eb);
          end
          mag = (sa == sb) ? mBig + mSmall : mBig - mSmall;
          expR = eBig;
          if (mag != 0) begin
            if (mag >= 2048) begin
              mag = mag >> 1;
              expR++;
              carry = 1'b1;
            end
            while (mag < 1024) begin
              mag = mag << 1;
              expR--;
            end
            if (expR < 1) res = {sBig, 15'd0};
            else if (expR > 30) res = {sBig, 5'h1F, 10'd0};
            else res = {sBig, expR[4:0], mag[9:0]};
          end
        end
      end
      fpuPkg::FPU_MUL: begin
        arith = 1'b1;
        if (special) res = fpuPkg::CANON_NAN;
        else if (ea == 0 || eb == 0) res = {sa ^ sb, 15'd0};
        else begin
          mag = ma * mb;
          expR = ea + eb - 15;
          if (mag >= (1 << 21)) begin
            mag = mag >> 1;
            expR++;
          end
          mag = mag >> 10;
          if (expR < 1) res = {sa ^ sb, 15'd0};
          else if (expR > 30) res = {sa ^ sb, 5'h1F, 10'd0};
          else res = {sa ^ sb, expR[4:0], mag[9:0]};
        end
      end
      fpuPkg::FPU_SHL: begin
        res = a << sh;
        carry = (sh == 0) ? 1'b0 : a[16 - sh];
      end
      fpuPkg::FPU_SHR: begin
        res = a >> sh;
        carry = (sh == 0) ? 1'b0 : a[sh - 1];
      end
      default: res = '0;
    endcase
    cc = '0;
    if (o != fpuPkg::FPU_DIV) begin
      cc[fpuPkg::CC_Z] = (res[14:0] == 15'd0);
      cc[fpuPkg::CC_C] = carry;
      cc[fpuPkg::CC_N] = arith & res[15];
      cc[fpuPkg::CC_V] = arith & (res[14:10] == 5'h1F);
    end
  endtask

  // #########################################################################
  // Compare tasks
  // #########################################################################

  task automatic checkWord(input string name, input logic [15:0] expected,
                           input logic [15:0] actual);
    checks++;
    if (actual !== expected) begin
      valueErrors++;
      $display("FAIL %s: fpuOut expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic checkCond(input string name, input logic [3:0] expected,
                           input logic [3:0] actual);
    checks++;
    if (actual !== expected) begin
      valueErrors++;
      $display("FAIL %s: condCodes expected %b, actual %b", name, expected, actual);
    end
  endtask

  task automatic checkOp(input string name, input fpuPkg::fpuOp_t expected,
                         input fpuPkg::fpuOp_t actual);
    checks++;
    if (actual !== expected) begin
      valueErrors++;
      $display("FAIL %s: op expected %0d, actual %0d", name, expected, actual);
    end
  endtask

  // Every pulse must match the oldest outstanding operation
  always @(negedge clk) begin : monitor
    string          name;
    fpuPkg::fpuOp_t sampled;
    if (rstN && resultValid === 1'b1) begin
      if (expWord.size() == 0) begin
        protoErrors++;
        $display("ERROR: resultValid pulsed with no operation outstanding");
      end else begin
        name = expName.pop_front();
        sampled = (sampledOps.size() != 0) ? sampledOps.pop_front() : fpuPkg::FPU_DIV;
        checkOp(name, expOp.pop_front(), sampled);
        checkWord(name, expWord.pop_front(), fpuOut);
        checkCond(name, expCond.pop_front(), condCodes);
        if (expCycle.pop_front() != cycle) begin
          protoErrors++;
          $display("ERROR: %s: result arrived in the wrong cycle", name);
        end
      end
    end
  end

  // #########################################################################
  // Stimulus
  // #########################################################################

  task automatic issueOp(input string name, input fpuPkg::fpuOp_t o,
                         input logic [15:0] a, input logic [15:0] b);
    logic [15:0] res;
    logic [3:0]  cc;
    modelOp(o, a, b, res, cc);
    opValid = 1'b1;
    op = o;
    fpuIn1 = a;
    fpuIn2 = b;
    expWord.push_back(res);
    expCond.push_back(cc);
    expOp.push_back(o);
    expName.push_back(name);
    expCycle.push_back(cycle + 1);
    @(negedge clk);
  endtask

  // Operands change while idle and must be ignored
  task automatic idleCycles(input int n);
    opValid = 1'b0;
    fpuIn1 = randBits(16);
    fpuIn2 = randBits(16);
    repeat (n) @(negedge clk);
  endtask

  task automatic drainResults(input string phase);
    int waited;
    waited = 0;
    while (expWord.size() != 0 && waited < DRAIN_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (expWord.size() != 0) begin
      protoErrors++;
      $display("ERROR: %s: no result within timeout", phase);
      expWord.delete();
      expCond.delete();
      expOp.delete();
      expName.delete();
      expCycle.delete();
      sampledOps.delete();
    end
  endtask

  initial begin
    fpuPkg::fpuOp_t o;
    logic [15:0]    a;
    logic [15:0]    b;
    logic [2:0]     v;
    logic           signB;
    clk = 1'b0;
    rstN = 1'b0;
    opValid = 1'b0;
    op = fpuPkg::FPU_ADD;
    fpuIn1 = '0;
    fpuIn2 = '0;
    lfsrState = 16'd1906;
    cycle = 0;
    checks = 0;
    valueErrors = 0;
    protoErrors = 0;
    repeat (4) @(negedge clk);
    rstN = 1'b1;

    // Idle after reset
    for (int i = 0; i < 5; i++) begin
      if (resultValid !== 1'b0) begin
        protoErrors++;
        $display("ERROR: resultValid not low after reset with no strobe");
      end
      checkWord("reset", 16'h0000, fpuOut);
      checkCond("reset", 4'b0000, condCodes);
      idleCycles(1);
    end

    // Directed corners
    issueOp("add carry", fpuPkg::FPU_ADD, 16'h3C00, 16'h3C00);
    issueOp("sub cancel", fpuPkg::FPU_SUB, 16'h4500, 16'h4500);
    issueOp("add overflow", fpuPkg::FPU_ADD, 16'h7BFF, 16'h7BFF);
    issueOp("mul overflow", fpuPkg::FPU_MUL, 16'h7800, 16'hF800);
    issueOp("mul underflow", fpuPkg::FPU_MUL, 16'h0400, 16'h0400);
    issueOp("add special", fpuPkg::FPU_ADD, 16'h7C00, 16'h3C00);
    issueOp("mul special", fpuPkg::FPU_MUL, 16'h7E01, 16'h0000);
    issueOp("sub subnormal", fpuPkg::FPU_SUB, 16'h0001, 16'h3C00);
    idleCycles(2);
    issueOp("shl carry", fpuPkg::FPU_SHL, 16'h8001, 16'h0001);
    issueOp("shr carry", fpuPkg::FPU_SHR, 16'h8001, 16'hFFF1);
    issueOp("shr zero", fpuPkg::FPU_SHR, 16'h8001, 16'h0000);
    issueOp("div", fpuPkg::FPU_DIV, 16'h3C00, 16'h3C00);
    idleCycles(1);
    drainResults("directed");

    // Random ops, mostly back to back with random gaps
    for (int n = 0; n < RANDOM_OPS; n++) begin
      v = randBits(3);
      if (v > 5) v = v - 3'd6;
      o = fpuPkg::fpuOp_t'(v);
      a = randOperand();
      b = randOperand();
      if ((o == fpuPkg::FPU_ADD || o == fpuPkg::FPU_SUB) && randBits(2) == 0) begin
        signB = randBits(1);
        b = {signB, a[14:0]};
      end
      issueOp($sformatf("random %0d", n), o, a, b);
      if (randBits(3) == 0) begin
        idleCycles(randBits(2) + 1);
      end
    end
    idleCycles(1);
    drainResults("random");
    idleCycles(4);

    $display("Summary: %0d checks, %0d value errors, %0d protocol errors",
             checks, valueErrors, protoErrors);
    if (valueErrors + protoErrors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule : fpuTb

//--- vlog.f
fpuPkg.sv
fpuUnpack.sv
fpuAddSub.sv
fpuMul.sv
fpuResult.sv
fpu.sv
fpuTb.sv

//--- Bender.yml
package:
  name: fpu

sources:
  - files:
      - fpuPkg.sv
      - fpuUnpack.sv
      - fpuAddSub.sv
      - fpuMul.sv
      - fpuResult.sv
      - fpu.sv
  - target: test
    files:
      - fpuTb.sv
